/* Bender.yml */
package:
  name: edm_pulse_monitor

sources:
  - hdl/edm_pkg.sv
  - hdl/pulse_classifier.sv
  - hdl/pulse_tally.sv
  - hdl/rate_divider.sv
  - hdl/edm_csr_axil.sv
  - hdl/pulse_monitor_top.sv
  - target: test
    files:
      - verif/pulse_monitor_tb.sv

/* hdl/edm_csr_axil.sv */
// axi4-lite register block of the pulse monitor
// holds the thresholds, latches the last rates and window total,
// and keeps the overrun and rates_fresh status flags
`default_nettype none

module edm_csr_axil (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire edm_pkg::axil_req_t  axil_req,
    output edm_pkg::axil_rsp_t       axil_rsp,
    output edm_pkg::thresh_t         thresh,
    input  wire edm_pkg::tally_t     snap,
    input  wire logic                snap_valid,
    input  wire edm_pkg::rates_t     rates,
    input  wire logic                rates_valid,
    input  wire logic                overrun
);

    logic            awready_q;  // drives awready and wready together
    logic            arready_q;
    logic            bvalid_q;
    logic            rvalid_q;
    logic [1:0]      bresp_q;
    logic [1:0]      rresp_q;
    logic [31:0]     rdata_q;
    logic [31:0]     rd_mux;
    logic            rd_err;
    logic            wr_err;
    logic            wr_fire;
    logic            rd_fire;
    logic            overrun_flag;
    logic            rates_fresh;
    logic [15:0]     total_q;
    edm_pkg::rates_t rates_q;

    function automatic logic [15:0] merge16(
        input logic [15:0] old,
        input logic [31:0] data,
        input logic [3:0]  strb
    );
        logic [15:0] res;
        res = old;
        if (strb[0])
            res[7:0] = data[7:0];
        if (strb[1])
            res[15:8] = data[15:8];
        return res;
    endfunction

    assign wr_fire = awready_q && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = arready_q && axil_req.arvalid;
    assign wr_err  = axil_req.awaddr > edm_pkg::REG_TOTAL || axil_req.awaddr[1:0] != 2'b00;

    always_comb
    begin
        rd_mux = '0;
        rd_err = 1'b0;
        case (axil_req.araddr)
            edm_pkg::REG_V_OPEN:    rd_mux = {{16{thresh.v_open[15]}}, thresh.v_open};
            edm_pkg::REG_V_SHORT:   rd_mux = {{16{thresh.v_short[15]}}, thresh.v_short};
            edm_pkg::REG_I_DIS:     rd_mux = {{16{thresh.i_discharge[15]}}, thresh.i_discharge};
            edm_pkg::REG_ARC_DELAY: rd_mux = {16'd0, thresh.arc_delay};
            edm_pkg::REG_STATUS:    rd_mux = {30'd0, rates_fresh, overrun_flag};
            edm_pkg::REG_RATES:     rd_mux = rates_q;
            edm_pkg::REG_TOTAL:     rd_mux = {16'd0, total_q};
            default:                rd_err = 1'b1;  // unmapped, data stays zero
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            awready_q          <= 1'b0;
            arready_q          <= 1'b0;
            bvalid_q           <= 1'b0;
            rvalid_q           <= 1'b0;
            bresp_q            <= edm_pkg::RESP_OKAY;
            rresp_q            <= edm_pkg::RESP_OKAY;
            rdata_q            <= '0;
            thresh.v_open      <= edm_pkg::V_OPEN_RST;
            thresh.v_short     <= edm_pkg::V_SHORT_RST;
            thresh.i_discharge <= edm_pkg::I_DIS_RST;
            thresh.arc_delay   <= edm_pkg::ARC_DELAY_RST;
            overrun_flag       <= 1'b0;
            rates_fresh        <= 1'b0;
            rates_q            <= '0;
            total_q            <= '0;
        end
        else
        begin
            // one-cycle ready pulses, held off while a response is pending
            awready_q <= axil_req.awvalid && axil_req.wvalid && !bvalid_q && !awready_q;
            arready_q <= axil_req.arvalid && !rvalid_q && !arready_q;
            if (axil_req.bready)
                bvalid_q <= 1'b0;
            if (axil_req.rready)
                rvalid_q <= 1'b0;
            if (wr_fire)
            begin
                bvalid_q <= 1'b1;
                bresp_q  <= wr_err ? edm_pkg::RESP_SLVERR : edm_pkg::RESP_OKAY;
                case (axil_req.awaddr)
                    edm_pkg::REG_V_OPEN:
                        thresh.v_open <= merge16(thresh.v_open, axil_req.wdata, axil_req.wstrb);
                    edm_pkg::REG_V_SHORT:
                        thresh.v_short <= merge16(thresh.v_short, axil_req.wdata, axil_req.wstrb);
                    edm_pkg::REG_I_DIS:
                        thresh.i_discharge <= merge16(thresh.i_discharge, axil_req.wdata,
                                                      axil_req.wstrb);
                    edm_pkg::REG_ARC_DELAY:
                        thresh.arc_delay <= merge16(thresh.arc_delay, axil_req.wdata,
                                                    axil_req.wstrb);
                    edm_pkg::REG_STATUS:
                        if (axil_req.wdata[0] && axil_req.wstrb[0])
                            overrun_flag <= 1'b0;  // write 1 to clear
                    default: ;  // rates and total are read only
                endcase
            end
            if (rd_fire)
            begin
                rvalid_q <= 1'b1;
                rdata_q  <= rd_mux;
                rresp_q  <= rd_err ? edm_pkg::RESP_SLVERR : edm_pkg::RESP_OKAY;
                if (axil_req.araddr == edm_pkg::REG_RATES)
                    rates_fresh <= 1'b0;
            end
            // new events win over a clear in the same cycle
            if (overrun)
                overrun_flag <= 1'b1;
            if (rates_valid)
            begin
                rates_q     <= rates;
                rates_fresh <= 1'b1;
            end
            if (snap_valid)
                total_q <= snap.total;
        end
    end

    always_comb
    begin
        axil_rsp.awready = awready_q;
        axil_rsp.wready  = awready_q;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.arready = arready_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
        axil_rsp.rvalid  = rvalid_q;
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_q && !axil_req.bready |=> bvalid_q && $stable(bresp_q));

endmodule

`default_nettype wire

/* hdl/edm_pkg.sv */
// shared types, pulse encodings and register map of the edm pulse monitor
// blocks refer to everything here by scoped name
`default_nettype none

package edm_pkg;

    localparam int CNT_W = 16;  // window counter width

    // threshold values after reset
    localparam logic signed [15:0] V_OPEN_RST    = 16'sd60;
    localparam logic signed [15:0] V_SHORT_RST   = 16'sd5;
    localparam logic signed [15:0] I_DIS_RST     = 16'sd5;
    localparam logic [15:0]        ARC_DELAY_RST = 16'd10;

    // register offsets on the axi4-lite port
    localparam logic [7:0] REG_V_OPEN    = 8'h00;
    localparam logic [7:0] REG_V_SHORT   = 8'h04;
    localparam logic [7:0] REG_I_DIS     = 8'h08;
    localparam logic [7:0] REG_ARC_DELAY = 8'h0C;
    localparam logic [7:0] REG_STATUS    = 8'h10;  // bit0 overrun, bit1 rates_fresh
    localparam logic [7:0] REG_RATES     = 8'h14;
    localparam logic [7:0] REG_TOTAL     = 8'h18;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [2:0] {
        NORMAL_DIS = 3'd0,
        ARC_DIS    = 3'd1,
        OPEN_DIS   = 3'd2,
        SHORT_DIS  = 3'd3,
        INTERVAL   = 3'd4
    } pulse_type_t;

    typedef struct packed {
        logic signed [15:0] voltage;
        logic signed [15:0] current;
    } sample_t;

    typedef struct packed {
        logic signed [15:0] v_open;       // at or above this the gap is open
        logic signed [15:0] v_short;      // at or below this the gap is shorted
        logic signed [15:0] i_discharge;  // above this current flows
        logic [15:0]        arc_delay;    // open samples needed before a normal breakdown
    } thresh_t;

    typedef struct packed {
        logic [CNT_W-1:0] normal;
        logic [CNT_W-1:0] arc;
        logic [CNT_W-1:0] open;
        logic [CNT_W-1:0] short;
        logic [CNT_W-1:0] total;
    } tally_t;

    // short in the top byte so the struct maps straight onto REG_RATES
    typedef struct packed {
        logic [7:0] short;
        logic [7:0] open;
        logic [7:0] arc;
        logic [7:0] normal;
    } rates_t;

    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axil_rsp_t;

endpackage

`default_nettype wire

/* hdl/pulse_classifier.sv */
// classifies each accepted gap sample into one of the five pulse types
// a sample is taken when sample_valid and machining are both high,
// its type comes out one cycle later with type_valid
`default_nettype none

module pulse_classifier (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire edm_pkg::sample_t      sample,
    input  wire logic                  sample_valid,
    input  wire logic                  machining,
    input  wire edm_pkg::thresh_t      thresh,
    output edm_pkg::pulse_type_t       pulse_type,
    output logic                       type_valid
);

    edm_pkg::pulse_type_t type_nxt;
    logic [15:0]          open_run;  // consecutive open samples, saturating
    logic                 accept;

    assign accept = sample_valid && machining;

    // pulse_type also holds the previous accepted type for the arc rule
    always_comb
    begin
        if (sample.voltage >= thresh.v_open)
            type_nxt = edm_pkg::OPEN_DIS;
        else if (sample.voltage > thresh.v_short && sample.current > thresh.i_discharge)
        begin
            // breakdown after too short an open delay is an arc
            if (open_run >= thresh.arc_delay || pulse_type == edm_pkg::NORMAL_DIS)
                type_nxt = edm_pkg::NORMAL_DIS;
            else
                type_nxt = edm_pkg::ARC_DIS;
        end
        else if (sample.voltage > thresh.v_short)
            type_nxt = edm_pkg::OPEN_DIS;  // voltage up, no current
        else if (sample.current > thresh.i_discharge)
            type_nxt = edm_pkg::SHORT_DIS;
        else
            type_nxt = edm_pkg::INTERVAL;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pulse_type <= edm_pkg::INTERVAL;
            type_valid <= 1'b0;
            open_run   <= '0;
        end
        else
        begin
            type_valid <= accept;
            if (accept)
            begin
                pulse_type <= type_nxt;
                if (type_nxt != edm_pkg::OPEN_DIS)
                    open_run <= '0;
                else if (open_run != '1)
                    open_run <= open_run + 16'd1;
            end
        end
    end

    a_type_legal: assert property (@(posedge clk) disable iff (!rst_n)
        type_valid |-> pulse_type <= edm_pkg::INTERVAL);

endmodule

`default_nettype wire

/* hdl/pulse_monitor_top.sv */
// edm pulse monitor top level
// samples are classified and counted per window, window_close starts the
// rate computation, and everything is read back over axi4-lite
`default_nettype none

module pulse_monitor_top (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire edm_pkg::sample_t    sample,
    input  wire logic                sample_valid,
    input  wire logic                machining,
    input  wire logic                window_close,
    input  wire edm_pkg::axil_req_t  axil_req,
    output edm_pkg::axil_rsp_t       axil_rsp
);

    edm_pkg::thresh_t     thresh;
    edm_pkg::pulse_type_t pulse_type;
    logic                 type_valid;
    edm_pkg::tally_t      snap;
    logic                 snap_valid;
    edm_pkg::rates_t      rates;
    logic                 rates_valid;
    logic                 overrun;

    edm_csr_axil csr0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .thresh      (thresh),
        .snap        (snap),
        .snap_valid  (snap_valid),
        .rates       (rates),
        .rates_valid (rates_valid),
        .overrun     (overrun)
    );

    pulse_classifier classifier0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .machining    (machining),
        .thresh       (thresh),
        .pulse_type   (pulse_type),
        .type_valid   (type_valid)
    );

    pulse_tally tally0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .pulse_type   (pulse_type),
        .type_valid   (type_valid),
        .window_close (window_close),
        .snap         (snap),
        .snap_valid   (snap_valid)
    );

    rate_divider divider0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .snap        (snap),
        .snap_valid  (snap_valid),
        .rates       (rates),
        .rates_valid (rates_valid),
        .overrun     (overrun)
    );

endmodule

`default_nettype wire

/* hdl/pulse_tally.sv */
// per-type pulse counters over one measurement window
// window_close copies the counts, with any pulse of the same edge, into snap
// and restarts counting from zero
`default_nettype none

module pulse_tally (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire edm_pkg::pulse_type_t  pulse_type,
    input  wire logic                  type_valid,
    input  wire logic                  window_close,
    output edm_pkg::tally_t            snap,
    output logic                       snap_valid
);

    edm_pkg::tally_t cnt;
    edm_pkg::tally_t cnt_nxt;

    function automatic logic [edm_pkg::CNT_W-1:0] sat_inc(
        input logic [edm_pkg::CNT_W-1:0] v,
        input logic                      en
    );
        if (en && v != '1)
            return v + 1'b1;
        return v;
    endfunction

    // interval pulses only show up in the total
    always_comb
    begin
        cnt_nxt.normal = sat_inc(cnt.normal, type_valid && pulse_type == edm_pkg::NORMAL_DIS);
        cnt_nxt.arc    = sat_inc(cnt.arc, type_valid && pulse_type == edm_pkg::ARC_DIS);
        cnt_nxt.open   = sat_inc(cnt.open, type_valid && pulse_type == edm_pkg::OPEN_DIS);
        cnt_nxt.short  = sat_inc(cnt.short, type_valid && pulse_type == edm_pkg::SHORT_DIS);
        cnt_nxt.total  = sat_inc(cnt.total, type_valid);
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt        <= '0;
            snap_valid <= 1'b0;
        end
        else
        begin
            snap_valid <= window_close;
            if (window_close)
                cnt <= '0;
            else
                cnt <= cnt_nxt;
        end
    end

    always_ff @(posedge clk)
    begin
        if (window_close)
            snap <= cnt_nxt;  // same edge as the clear, nothing lost
    end

endmodule

`default_nettype wire

/* hdl/rate_divider.sv */
// turns one window snapshot into four whole-percent rates
// one shared restoring divider runs normal, arc, open and short in turn,
// 17 cycles each, and rates_valid pulses after the last one
`default_nettype none

module rate_divider (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire edm_pkg::tally_t  snap,
    input  wire logic             snap_valid,
    output edm_pkg::rates_t       rates,
    output logic                  rates_valid,
    output logic                  overrun
);

    typedef enum logic [1:0] {S_IDLE, S_LOAD, S_DIV} state_t;

    state_t          state;
    edm_pkg::tally_t snap_q;
    logic [1:0]      idx;      // 0 normal, 1 arc, 2 open, 3 short
    logic [3:0]      step;
    logic [15:0]     rem;      // partial remainder, always below the total
    logic [15:0]     num;      // numerator bits shift out, quotient bits shift in
    logic [3:0][7:0] rate_q;
    logic [15:0]     cnt_sel;
    logic [23:0]     scaled;
    logic [16:0]     shifted;
    logic [16:0]     diff;
    logic            q_bit;

    always_comb
    begin
        case (idx)
            2'd0:    cnt_sel = snap_q.normal;
            2'd1:    cnt_sel = snap_q.arc;
            2'd2:    cnt_sel = snap_q.open;
            default: cnt_sel = snap_q.short;
        endcase
    end

    // count <= total keeps 100*count/total under 2^16, so 16 steps are enough
    assign scaled  = cnt_sel * 24'd100;
    assign shifted = {rem, num[15]};
    assign diff    = shifted - {1'b0, snap_q.total};
    assign q_bit   = shifted >= {1'b0, snap_q.total};
    assign rates   = edm_pkg::rates_t'(rate_q);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= S_IDLE;
            idx         <= '0;
            step        <= '0;
            rates_valid <= 1'b0;
            overrun     <= 1'b0;
        end
        else
        begin
            rates_valid <= 1'b0;
            overrun     <= snap_valid && state != S_IDLE;  // busy, snapshot dropped
            case (state)
                S_IDLE:
                    if (snap_valid)
                    begin
                        idx   <= 2'd0;
                        state <= S_LOAD;
                    end
                S_LOAD:
                begin
                    step  <= 4'd0;
                    state <= S_DIV;
                end
                default:
                begin
                    step <= step + 4'd1;
                    if (step == 4'd15)
                    begin
                        idx <= idx + 2'd1;
                        if (idx == 2'd3)
                        begin
                            rates_valid <= 1'b1;
                            state       <= S_IDLE;
                        end
                        else
                            state <= S_LOAD;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && snap_valid)
            snap_q <= snap;
        if (state == S_LOAD)
        begin
            rem <= {8'd0, scaled[23:16]};
            num <= scaled[15:0];
        end
        else if (state == S_DIV)
        begin
            rem <= q_bit ? diff[15:0] : shifted[15:0];
            num <= {num[14:0], q_bit};
            if (step == 4'd15)
                rate_q[idx] <= (snap_q.total == '0) ? 8'd0 : {num[6:0], q_bit};  // empty window
        end
    end

    a_done_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        rates_valid |-> state == S_IDLE && $past(state) == S_DIV && $past(idx) == 2'd3);

endmodule

`default_nettype wire

/* verif/pulse_monitor_tb.sv */
// directed testbench for the edm pulse monitor
// drives samples and window closes, reads results over axi4-lite and
// compares them with a reference model of the classification and rate rules
`default_nettype none

module pulse_monitor_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                clk;
    logic                rst_n;
    edm_pkg::sample_t    smp;
    logic                sample_valid;
    logic                machining;
    logic                window_close;
    edm_pkg::axil_req_t  req;
    edm_pkg::axil_rsp_t  rsp;

    // reference model state
    int                   m_v_open;
    int                   m_v_short;
    int                   m_i_dis;
    int                   m_arc_delay;
    int                   open_run;
    edm_pkg::pulse_type_t prev_type;
    int                   live_cnt[4];  // normal, arc, open, short
    int                   live_total;
    int                   exp_cnt[4];
    int                   exp_total;
    edm_pkg::rates_t      last_rates;
    logic [31:0]          lcg_state;
    int                   cycles;

    pulse_monitor_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample       (smp),
        .sample_valid (sample_valid),
        .machining    (machining),
        .window_close (window_close),
        .axil_req     (req),
        .axil_rsp     (rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // whole run is a few thousand cycles, so this only trips on a hang
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= 20000)
        begin
            $display("timeout: test did not finish within %0d clock cycles", cycles);
            $display("Verification failed");
            $fatal(1);
        end
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:16];
    endfunction

    function automatic int percent_of(input int cnt, input int total);
        if (total == 0)
            return 0;
        return (cnt * 100) / total;  // floor
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp)
        else
        begin
            $display("FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // every task starts and ends 2 ns after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        req.awaddr  = addr;
        req.wdata   = data;
        req.wstrb   = strb;
        req.awvalid = 1'b1;
        req.wvalid  = 1'b1;
        do
            next_cycle();
        while (!rsp.awready);
        check_value("wready with awready", rsp.wready, 1);  // both channels ready together
        next_cycle();  // address and data taken on this edge
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        while (!rsp.bvalid)
            next_cycle();
        resp = rsp.bresp;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        req.araddr  = addr;
        req.arvalid = 1'b1;
        do
            next_cycle();
        while (!rsp.arready);
        next_cycle();
        req.arvalid = 1'b0;
        while (!rsp.rvalid)
            next_cycle();
        data = rsp.rdata;
        resp = rsp.rresp;
    endtask

    task automatic model_sample(input int v, input int i);
        edm_pkg::pulse_type_t t;
        if (v >= m_v_open)
            t = edm_pkg::OPEN_DIS;
        else if (v > m_v_short && i > m_i_dis)
            t = (open_run >= m_arc_delay || prev_type == edm_pkg::NORMAL_DIS) ?
                edm_pkg::NORMAL_DIS : edm_pkg::ARC_DIS;
        else if (v > m_v_short)
            t = edm_pkg::OPEN_DIS;
        else if (i > m_i_dis)
            t = edm_pkg::SHORT_DIS;
        else
            t = edm_pkg::INTERVAL;
        if (t == edm_pkg::OPEN_DIS)
        begin
            if (open_run < 65535)
                open_run++;
        end
        else
            open_run = 0;
        prev_type = t;
        if (t != edm_pkg::INTERVAL)
            live_cnt[int'(t)]++;
        live_total++;  // interval only lands here
    endtask

    task automatic send_sample(input int v, input int i, input bit mach);
        smp.voltage  = 16'(v);
        smp.current  = 16'(i);
        sample_valid = 1'b1;
        machining    = mach;
        if (mach)
            model_sample(v, i);
        next_cycle();
        sample_valid = 1'b0;
    endtask

    task automatic close_window();
        window_close = 1'b1;
        next_cycle();
        window_close = 1'b0;
        exp_cnt    = live_cnt;
        exp_total  = live_total;
        live_cnt   = '{0, 0, 0, 0};
        live_total = 0;
    endtask

    task automatic wait_rates();
        logic [31:0] d;
        logic [1:0]  r;
        d = '0;
        while (!d[1])
            axil_read(edm_pkg::REG_STATUS, d, r);  // poll rates_fresh
    endtask

    task automatic check_window(input bit with_total);
        logic [31:0] d;
        logic [1:0]  r;
        wait_rates();
        if (with_total)
        begin
            axil_read(edm_pkg::REG_TOTAL, d, r);
            check_value("REG_TOTAL", d, exp_total);
        end
        axil_read(edm_pkg::REG_RATES, d, r);
        last_rates = edm_pkg::rates_t'(d);
        check_value("rate normal", last_rates.normal, percent_of(exp_cnt[0], exp_total));
        check_value("rate arc", last_rates.arc, percent_of(exp_cnt[1], exp_total));
        check_value("rate open", last_rates.open, percent_of(exp_cnt[2], exp_total));
        check_value("rate short", last_rates.short, percent_of(exp_cnt[3], exp_total));
        axil_read(edm_pkg::REG_STATUS, d, r);
        check_value("rates_fresh after rates read", d[1], 0);
    endtask

    task automatic read_reset_defaults();
        logic [31:0] d;
        logic [1:0]  r;
        axil_read(edm_pkg::REG_V_OPEN, d, r);
        check_value("v_open", d, 60);
        axil_read(edm_pkg::REG_V_SHORT, d, r);
        check_value("v_short", d, 5);
        axil_read(edm_pkg::REG_I_DIS, d, r);
        check_value("i_discharge", d, 5);
        axil_read(edm_pkg::REG_ARC_DELAY, d, r);
        check_value("arc_delay", d, 10);
        axil_read(edm_pkg::REG_STATUS, d, r);
        check_value("REG_STATUS", d, 0);
        axil_read(edm_pkg::REG_RATES, d, r);
        check_value("REG_RATES", d, 0);
        axil_read(edm_pkg::REG_TOTAL, d, r);
        check_value("REG_TOTAL", d, 0);
        axil_read(8'h1C, d, r);
        check_value("rresp unmapped", r, edm_pkg::RESP_SLVERR);
        check_value("rdata unmapped", d, 0);
    endtask

    task automatic configure_thresholds();
        logic [31:0] d;
        logic [1:0]  r;
        axil_write(edm_pkg::REG_V_OPEN, 32'h0000_7F50, 4'b0001, r);  // upper byte masked off
        check_value("bresp v_open", r, edm_pkg::RESP_OKAY);
        axil_write(edm_pkg::REG_V_SHORT, 32'd10, 4'hF, r);
        axil_write(edm_pkg::REG_I_DIS, 32'd20, 4'hF, r);
        axil_write(edm_pkg::REG_ARC_DELAY, 32'd3, 4'hF, r);
        axil_read(edm_pkg::REG_V_OPEN, d, r);
        check_value("v_open after strobe write", d, 80);
        axil_read(edm_pkg::REG_V_SHORT, d, r);
        check_value("v_short", d, 10);
        axil_read(edm_pkg::REG_I_DIS, d, r);
        check_value("i_discharge", d, 20);
        axil_read(edm_pkg::REG_ARC_DELAY, d, r);
        check_value("arc_delay", d, 3);
        m_v_open    = 80;
        m_v_short   = 10;
        m_i_dis     = 20;
        m_arc_delay = 3;
        axil_write(edm_pkg::REG_RATES, 32'hFFFF_FFFF, 4'hF, r);
        check_value("bresp rates write", r, edm_pkg::RESP_OKAY);
        axil_read(edm_pkg::REG_RATES, d, r);
        check_value("REG_RATES after write", d, 0);
        axil_write(8'h40, 32'd1, 4'hF, r);
        check_value("bresp unmapped", r, edm_pkg::RESP_SLVERR);
    endtask

    task automatic random_window();
        int v;
        int i;
        repeat (200)
        begin
            v = int'(next_rand() % 110) - 10;
            i = int'(next_rand() % 60) - 10;
            send_sample(v, i, 1'b1);
        end
        close_window();
        check_window(1'b1);
    endtask

    task automatic arc_rule_windows();
        // two open samples, below an arc_delay of 3
        send_sample(0, 0, 1'b1);
        send_sample(90, 0, 1'b1);
        send_sample(90, 0, 1'b1);
        send_sample(50, 40, 1'b1);
        close_window();
        check_window(1'b1);
        check_value("arc rate after short open run", last_rates.arc, 25);
        send_sample(0, 0, 1'b1);
        repeat (3)
            send_sample(90, 0, 1'b1);
        send_sample(50, 40, 1'b1);
        send_sample(50, 40, 1'b1);  // follows a normal one
        close_window();
        check_window(1'b1);
        check_value("normal rate after long open run", last_rates.normal, 33);
        check_value("arc rate after long open run", last_rates.arc, 0);
    endtask

    task automatic machining_gate();
        repeat (5)
            send_sample(50, 40, 1'b0);
        close_window();
        check_window(1'b1);
        check_value("empty window normal rate", last_rates.normal, 0);
    endtask

    task automatic overrun_recovery();
        logic [31:0] d;
        logic [1:0]  r;
        int          v;
        int          i;
        repeat (12)
        begin
            v = int'(next_rand() % 110) - 10;
            i = int'(next_rand() % 60) - 10;
            send_sample(v, i, 1'b1);
        end
        close_window();
        repeat (4)
            next_cycle();
        window_close = 1'b1;  // divider still busy
        next_cycle();
        window_close = 1'b0;
        wait_rates();
        axil_read(edm_pkg::REG_STATUS, d, r);
        check_value("status overrun", d[0], 1);
        axil_write(edm_pkg::REG_STATUS, 32'h1, 4'hF, r);
        axil_read(edm_pkg::REG_STATUS, d, r);
        check_value("status overrun after clear", d[0], 0);
        check_window(1'b0);  // total now holds the dropped snapshot
    endtask

    initial
    begin
        rst_n        = 1'b0;
        smp          = '0;
        sample_valid = 1'b0;
        machining    = 1'b0;
        window_close = 1'b0;
        req          = '0;
        req.bready   = 1'b1;
        req.rready   = 1'b1;
        m_v_open     = 60;
        m_v_short    = 5;
        m_i_dis      = 5;
        m_arc_delay  = 10;
        open_run     = 0;
        prev_type    = edm_pkg::INTERVAL;
        live_cnt     = '{0, 0, 0, 0};
        live_total   = 0;
        exp_cnt      = '{0, 0, 0, 0};
        exp_total    = 0;
        lcg_state    = 32'd76;
        cycles       = 0;
        repeat (2)
            @(posedge clk);
        #2;
        rst_n = 1'b1;
        read_reset_defaults();
        configure_thresholds();
        random_window();
        arc_rule_windows();
        machining_gate();
        overrun_recovery();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hdl/edm_pkg.sv
hdl/pulse_classifier.sv
hdl/pulse_tally.sv
hdl/rate_divider.sv
hdl/edm_csr_axil.sv
hdl/pulse_monitor_top.sv
verif/pulse_monitor_tb.sv
